//--- read_pipe_pkg.sv
package read_pipe_pkg;

	// ====================
	// data and address widths
	// ====================

	localparam int DBW = 16;
	localparam int GBW = 24;
	localparam int VSIZE = 4;

	// configuration table
	localparam int N_CFG = 4;
	localparam int CFG_BW = $clog2(N_CFG);

	// chunk geometry, lengths run 1..MAX_BEATS
	localparam int MAX_BEATS = 4;
	localparam int BEAT_BW = $clog2(MAX_BEATS + 1);
	localparam int IDX_BW = 8;

	// slot count defaults, top level overrides
	localparam int N_SLOTS_DEF = 4;
	localparam int SLOT_BW_DEF = $clog2(N_SLOTS_DEF);

	// ====================
	// shared types
	// ====================

	// one configuration entry, stride and length counted in beats
	typedef struct packed {
		logic [GBW-1:0]     base;
		logic [GBW-1:0]     stride;
		logic [BEAT_BW-1:0] beats;
	} cfg_t;

	typedef struct packed {
		logic [CFG_BW-1:0] cfg_id;
		logic [IDX_BW-1:0] idx;
	} chunk_req_t;

	// dram beat, buffer word and output vector share this shape
	typedef logic [VSIZE-1:0][DBW-1:0] vec_t;

	typedef struct packed {
		vec_t data;
		logic last;
	} out_beat_t;

	typedef enum logic {
		CS_IDLE,
		CS_COLLECT
	} collect_state_e;

	typedef enum logic {
		RS_IDLE,
		RS_STREAM
	} readout_state_e;

endpackage

//--- chunk_head.sv
`timescale 1ns/1ps

module chunk_head #(
	parameter int SLOT_BW = read_pipe_pkg::SLOT_BW_DEF
) (
	input  logic                              i_clk,
	input  logic                              i_rst,
	input  read_pipe_pkg::chunk_req_t         i_req,
	input  logic                              i_req_rdy,
	output logic                              o_req_ack,
	input  read_pipe_pkg::cfg_t               i_cfg [read_pipe_pkg::N_CFG],
	output logic                              o_alloc_rdy,
	input  logic                              i_alloc_ack,
	input  logic [SLOT_BW-1:0]                i_alloc_slot,
	output logic                              o_addr_rdy,
	input  logic                              i_addr_ack,
	output logic [read_pipe_pkg::GBW-1:0]     o_addr_base,
	output logic [read_pipe_pkg::BEAT_BW-1:0] o_addr_beats,
	output logic                              o_wr_rdy,
	input  logic                              i_wr_ack,
	output logic [SLOT_BW-1:0]                o_wr_slot,
	output logic [read_pipe_pkg::BEAT_BW-1:0] o_wr_beats
);
	import read_pipe_pkg::*;

	cfg_t               cfg_sel;
	logic [GBW-1:0]     base_r;
	logic [BEAT_BW-1:0] beats_r;
	logic [SLOT_BW-1:0] slot_r;
	logic               bcast;
	logic               addr_done;
	logic               wr_done;
	logic               leave;

	assign cfg_sel = i_cfg[i_req.cfg_id];

	// head takes a new request only when fully empty
	assign o_req_ack = i_req_rdy && !o_alloc_rdy && !bcast;

	// broadcast, each branch drops out once it has acked
	assign o_addr_rdy = bcast && !addr_done;
	assign o_wr_rdy = bcast && !wr_done;
	assign leave = (addr_done || i_addr_ack) && (wr_done || i_wr_ack);

	assign o_addr_base = base_r;
	assign o_addr_beats = beats_r;
	assign o_wr_slot = slot_r;
	assign o_wr_beats = beats_r;

	always_ff @(posedge i_clk) begin
		if (o_req_ack) begin
			base_r <= cfg_sel.base + GBW'(i_req.idx) * cfg_sel.stride;
			beats_r <= cfg_sel.beats;
		end
		if (i_alloc_ack) begin
			slot_r <= i_alloc_slot;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_alloc_rdy <= 1'b0;
			bcast <= 1'b0;
			addr_done <= 1'b0;
			wr_done <= 1'b0;
		end else begin
			if (o_req_ack) begin
				o_alloc_rdy <= 1'b1;
			end else if (i_alloc_ack) begin
				o_alloc_rdy <= 1'b0;
			end
			// both branches served, chunk leaves the head
			if (i_alloc_ack) begin
				bcast <= 1'b1;
			end else if (leave) begin
				bcast <= 1'b0;
			end
			if (leave) begin
				addr_done <= 1'b0;
				wr_done <= 1'b0;
			end else begin
				if (i_addr_ack) begin
					addr_done <= 1'b1;
				end
				if (i_wr_ack) begin
					wr_done <= 1'b1;
				end
			end
		end
	end

endmodule

//--- chunk_allocator.sv
`timescale 1ns/1ps

module chunk_allocator #(
	parameter int  N_SLOTS = read_pipe_pkg::N_SLOTS_DEF,
	localparam int SLOT_BW = $clog2(N_SLOTS)
) (
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_alloc_rdy,
	output logic               o_alloc_ack,
	output logic [SLOT_BW-1:0] o_alloc_slot,
	input  logic               i_free
);
	localparam int CNT_BW = $clog2(N_SLOTS + 1);

	logic [SLOT_BW-1:0] head;
	logic [CNT_BW-1:0]  used;
	logic               full;

	// ====================
	// ring of slots
	// ====================

	// slots come back in allocation order, so one head pointer
	// and a counter are enough
	assign full = (used == CNT_BW'(N_SLOTS));

	assign o_alloc_ack = i_alloc_rdy && !full;
	assign o_alloc_slot = head;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			head <= '0;
		end else if (o_alloc_ack) begin
			if (head == SLOT_BW'(N_SLOTS - 1)) begin
				head <= '0;
			end else begin
				head <= head + 1'b1;
			end
		end
	end

	// ====================
	// occupancy
	// ====================

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			used <= '0;
		end else begin
			case ({o_alloc_ack, i_free})
				2'b10: begin
					used <= used + 1'b1;
				end
				2'b01: begin
					used <= used - 1'b1;
				end
				// alloc and free together, count unchanged
				default: begin
					used <= used;
				end
			endcase
		end
	end

endmodule

//--- dram_addr_looper.sv
`timescale 1ns/1ps

module dram_addr_looper (
	input  logic                              i_clk,
	input  logic                              i_rst,
	input  logic                              i_chunk_rdy,
	output logic                              o_chunk_ack,
	input  logic [read_pipe_pkg::GBW-1:0]     i_base,
	input  logic [read_pipe_pkg::BEAT_BW-1:0] i_beats,
	output logic                              o_dramra_rdy,
	input  logic                              i_dramra_ack,
	output logic [read_pipe_pkg::GBW-1:0]     o_dramra
);
	import read_pipe_pkg::*;

	// beats still to be issued, including the one on o_dramra
	logic [BEAT_BW-1:0] left;

	// next chunk only once the last address has gone out
	assign o_chunk_ack = i_chunk_rdy && !o_dramra_rdy;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_dramra_rdy <= 1'b0;
			left <= '0;
		end else if (o_chunk_ack) begin
			o_dramra_rdy <= 1'b1;
			left <= i_beats;
		end else if (i_dramra_ack) begin
			left <= left - 1'b1;
			if (left == BEAT_BW'(1)) begin
				o_dramra_rdy <= 1'b0;
			end
		end
	end

	// burst address walks up by one per beat
	always_ff @(posedge i_clk) begin
		if (o_chunk_ack) begin
			o_dramra <= i_base;
		end else if (i_dramra_ack) begin
			o_dramra <= o_dramra + 1'b1;
		end
	end

endmodule

//--- sram_write_collector.sv
`timescale 1ns/1ps

module sram_write_collector #(
	parameter int  SLOT_BW = read_pipe_pkg::SLOT_BW_DEF,
	localparam int ABW = SLOT_BW + $clog2(read_pipe_pkg::MAX_BEATS)
) (
	input  logic                              i_clk,
	input  logic                              i_rst,
	input  logic                              i_chunk_rdy,
	output logic                              o_chunk_ack,
	input  logic [SLOT_BW-1:0]                i_slot,
	input  logic [read_pipe_pkg::BEAT_BW-1:0] i_beats,
	input  logic                              i_dramrd_rdy,
	output logic                              o_dramrd_ack,
	input  read_pipe_pkg::vec_t               i_dramrd,
	output logic                              o_wen,
	output logic [ABW-1:0]                    o_waddr,
	output read_pipe_pkg::vec_t               o_wdata,
	output logic                              o_done_rdy,
	input  logic                              i_done_ack,
	output logic [SLOT_BW-1:0]                o_done_slot,
	output logic [read_pipe_pkg::BEAT_BW-1:0] o_done_beats
);
	import read_pipe_pkg::*;

	collect_state_e     state;
	logic [SLOT_BW-1:0] slot_r;
	logic [BEAT_BW-1:0] beats_r;
	logic [BEAT_BW-1:0] beat_cnt;
	logic               last_beat;

	assign o_chunk_ack = i_chunk_rdy && (state == CS_IDLE);

	// hold dram data back while the previous chunk waits on done
	assign o_dramrd_ack = i_dramrd_rdy && (state == CS_COLLECT) && !o_done_rdy;
	assign last_beat = (beat_cnt + 1'b1 == beats_r);

	// write straight through on the accepting edge
	assign o_wen = o_dramrd_ack;
	assign o_waddr = ABW'(slot_r * MAX_BEATS + beat_cnt);
	assign o_wdata = i_dramrd;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state <= CS_IDLE;
			beat_cnt <= '0;
			o_done_rdy <= 1'b0;
		end else begin
			if (i_done_ack) begin
				o_done_rdy <= 1'b0;
			end
			case (state)
				CS_IDLE: begin
					if (o_chunk_ack) begin
						state <= CS_COLLECT;
						beat_cnt <= '0;
					end
				end
				CS_COLLECT: begin
					if (o_dramrd_ack) begin
						if (last_beat) begin
							state <= CS_IDLE;
							o_done_rdy <= 1'b1;
						end else begin
							beat_cnt <= beat_cnt + 1'b1;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_chunk_ack) begin
			slot_r <= i_slot;
			beats_r <= i_beats;
		end
		// done payload stays put while the next chunk is latched
		if (o_dramrd_ack && last_beat) begin
			o_done_slot <= slot_r;
			o_done_beats <= beats_r;
		end
	end

endmodule

//--- local_buffer.sv
`timescale 1ns/1ps

module local_buffer #(
	parameter int  N_SLOTS = read_pipe_pkg::N_SLOTS_DEF,
	localparam int ABW = $clog2(N_SLOTS) + $clog2(read_pipe_pkg::MAX_BEATS)
) (
	input  logic                i_clk,
	input  logic                i_wen,
	input  logic [ABW-1:0]      i_waddr,
	input  read_pipe_pkg::vec_t i_wdata,
	input  logic [ABW-1:0]      i_raddr,
	output read_pipe_pkg::vec_t o_rdata
);
	import read_pipe_pkg::*;

	// each slot owns MAX_BEATS consecutive vectors
	localparam int DEPTH = N_SLOTS * MAX_BEATS;

	vec_t mem [DEPTH];

	always_ff @(posedge i_clk) begin
		if (i_wen) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// registered read, data one cycle after the address
	always_ff @(posedge i_clk) begin
		o_rdata <= mem[i_raddr];
	end

endmodule

//--- chunk_readout.sv
`timescale 1ns/1ps

module chunk_readout #(
	parameter int  N_SLOTS = read_pipe_pkg::N_SLOTS_DEF,
	localparam int SLOT_BW = $clog2(N_SLOTS),
	localparam int ABW = SLOT_BW + $clog2(read_pipe_pkg::MAX_BEATS)
) (
	input  logic                              i_clk,
	input  logic                              i_rst,
	input  logic                              i_done_rdy,
	output logic                              o_done_ack,
	input  logic [SLOT_BW-1:0]                i_done_slot,
	input  logic [read_pipe_pkg::BEAT_BW-1:0] i_done_beats,
	output logic [ABW-1:0]                    o_raddr,
	input  read_pipe_pkg::vec_t               i_rdata,
	output logic                              o_sramrd_rdy,
	input  logic                              i_sramrd_ack,
	output read_pipe_pkg::out_beat_t          o_sramrd,
	output logic                              o_free
);
	import read_pipe_pkg::*;

	localparam int CNT_BW = $clog2(N_SLOTS + 1);

	logic [SLOT_BW-1:0] q_slot [N_SLOTS];
	logic [BEAT_BW-1:0] q_beats [N_SLOTS];
	logic [SLOT_BW-1:0] wr_ptr;
	logic [SLOT_BW-1:0] rd_ptr;
	logic [CNT_BW-1:0]  q_cnt;
	readout_state_e     state;
	logic [SLOT_BW-1:0] cur_slot;
	logic [BEAT_BW-1:0] cur_beats;
	logic [BEAT_BW-1:0] out_beat;
	logic [BEAT_BW-1:0] next_beat;
	logic               last_beat;
	logic               load;

	function automatic logic [SLOT_BW-1:0] wrap_inc(input logic [SLOT_BW-1:0] ptr);
		if (ptr == SLOT_BW'(N_SLOTS - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// ====================
	// finished chunk queue
	// ====================

	assign o_done_ack = i_done_rdy && (q_cnt != CNT_BW'(N_SLOTS));

	always_ff @(posedge i_clk) begin
		if (o_done_ack) begin
			q_slot[wr_ptr] <= i_done_slot;
			q_beats[wr_ptr] <= i_done_beats;
		end
		if (load) begin
			cur_slot <= q_slot[rd_ptr];
			cur_beats <= q_beats[rd_ptr];
		end
	end

	// ====================
	// vector stream
	// ====================

	assign o_sramrd_rdy = (state == RS_STREAM);
	assign last_beat = (out_beat + 1'b1 == cur_beats);
	assign o_free = i_sramrd_ack && last_beat;
	assign o_sramrd = '{data: i_rdata, last: last_beat};

	// pick up the next chunk when idle or right behind a last ack
	assign load = (q_cnt != '0) && (!o_sramrd_rdy || o_free);

	// address runs one step ahead of the ack so the next vector
	// is there on the following cycle, and holds while stalled
	assign next_beat = i_sramrd_ack ? out_beat + 1'b1 : out_beat;
	assign o_raddr = load ? ABW'(q_slot[rd_ptr] * MAX_BEATS)
		: ABW'(cur_slot * MAX_BEATS + next_beat);

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_cnt <= '0;
			state <= RS_IDLE;
			out_beat <= '0;
		end else begin
			if (o_done_ack) begin
				wr_ptr <= wrap_inc(wr_ptr);
			end
			if (load) begin
				rd_ptr <= wrap_inc(rd_ptr);
			end
			if (o_done_ack && !load) begin
				q_cnt <= q_cnt + 1'b1;
			end else if (load && !o_done_ack) begin
				q_cnt <= q_cnt - 1'b1;
			end
			if (load) begin
				state <= RS_STREAM;
				out_beat <= '0;
			end else if (o_free) begin
				state <= RS_IDLE;
			end else if (i_sramrd_ack) begin
				out_beat <= next_beat;
			end
		end
	end

endmodule

//--- read_pipeline.sv
`timescale 1ns/1ps

module read_pipeline #(
	parameter int N_SLOTS = read_pipe_pkg::N_SLOTS_DEF
) (
	input  logic                          i_clk,
	input  logic                          i_rst,
	input  read_pipe_pkg::chunk_req_t     i_req,
	input  logic                          i_req_rdy,
	output logic                          o_req_ack,
	input  read_pipe_pkg::cfg_t           i_cfg [read_pipe_pkg::N_CFG],
	output logic                          o_dramra_rdy,
	input  logic                          i_dramra_ack,
	output logic [read_pipe_pkg::GBW-1:0] o_dramra,
	input  logic                          i_dramrd_rdy,
	output logic                          o_dramrd_ack,
	input  read_pipe_pkg::vec_t           i_dramrd,
	output logic                          o_sramrd_rdy,
	input  logic                          i_sramrd_ack,
	output read_pipe_pkg::out_beat_t      o_sramrd
);
	import read_pipe_pkg::*;

	localparam int SLOT_BW = $clog2(N_SLOTS);
	localparam int ABW = SLOT_BW + $clog2(MAX_BEATS);

	// ====================
	// internal channels
	// ====================

	// head to allocator
	logic               alloc_rdy;
	logic               alloc_ack;
	logic [SLOT_BW-1:0] alloc_slot;
	// head to address looper
	logic               addr_rdy;
	logic               addr_ack;
	logic [GBW-1:0]     addr_base;
	logic [BEAT_BW-1:0] addr_beats;
	// head to write collector
	logic               wr_rdy;
	logic               wr_ack;
	logic [SLOT_BW-1:0] wr_slot;
	logic [BEAT_BW-1:0] wr_beats;
	// buffer ports
	logic               wen;
	logic [ABW-1:0]     waddr;
	vec_t               wdata;
	logic [ABW-1:0]     raddr;
	vec_t               rdata;
	// collector to readout, readout back to allocator
	logic               done_rdy;
	logic               done_ack;
	logic [SLOT_BW-1:0] done_slot;
	logic [BEAT_BW-1:0] done_beats;
	logic               free;

	chunk_head #(.SLOT_BW(SLOT_BW)) u_head (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_req(i_req), .i_req_rdy(i_req_rdy), .o_req_ack(o_req_ack),
		.i_cfg(i_cfg),
		.o_alloc_rdy(alloc_rdy), .i_alloc_ack(alloc_ack), .i_alloc_slot(alloc_slot),
		.o_addr_rdy(addr_rdy), .i_addr_ack(addr_ack),
		.o_addr_base(addr_base), .o_addr_beats(addr_beats),
		.o_wr_rdy(wr_rdy), .i_wr_ack(wr_ack), .o_wr_slot(wr_slot), .o_wr_beats(wr_beats)
	);

	chunk_allocator #(.N_SLOTS(N_SLOTS)) u_alloc (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_alloc_rdy(alloc_rdy), .o_alloc_ack(alloc_ack), .o_alloc_slot(alloc_slot),
		.i_free(free)
	);

	dram_addr_looper u_addr (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_chunk_rdy(addr_rdy), .o_chunk_ack(addr_ack),
		.i_base(addr_base), .i_beats(addr_beats),
		.o_dramra_rdy(o_dramra_rdy), .i_dramra_ack(i_dramra_ack), .o_dramra(o_dramra)
	);

	sram_write_collector #(.SLOT_BW(SLOT_BW)) u_collect (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_chunk_rdy(wr_rdy), .o_chunk_ack(wr_ack), .i_slot(wr_slot), .i_beats(wr_beats),
		.i_dramrd_rdy(i_dramrd_rdy), .o_dramrd_ack(o_dramrd_ack), .i_dramrd(i_dramrd),
		.o_wen(wen), .o_waddr(waddr), .o_wdata(wdata),
		.o_done_rdy(done_rdy), .i_done_ack(done_ack),
		.o_done_slot(done_slot), .o_done_beats(done_beats)
	);

	local_buffer #(.N_SLOTS(N_SLOTS)) u_buf (
		.i_clk(i_clk),
		.i_wen(wen), .i_waddr(waddr), .i_wdata(wdata),
		.i_raddr(raddr), .o_rdata(rdata)
	);

	chunk_readout #(.N_SLOTS(N_SLOTS)) u_readout (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_done_rdy(done_rdy), .o_done_ack(done_ack),
		.i_done_slot(done_slot), .i_done_beats(done_beats),
		.o_raddr(raddr), .i_rdata(rdata),
		.o_sramrd_rdy(o_sramrd_rdy), .i_sramrd_ack(i_sramrd_ack), .o_sramrd(o_sramrd),
		.o_free(free)
	);

endmodule

//--- tb_read_pipeline_assertions.sv
`timescale 1ns/1ps

module tb_read_pipeline_assertions (
	input logic                          i_clk,
	input logic                          i_rst,
	input logic                          i_req_rdy,
	input logic                          o_req_ack,
	input logic                          o_dramra_rdy,
	input logic                          i_dramra_ack,
	input logic [read_pipe_pkg::GBW-1:0] o_dramra,
	input logic                          i_dramrd_rdy,
	input logic                          o_dramrd_ack,
	input logic                          o_sramrd_rdy,
	input logic                          i_sramrd_ack,
	input read_pipe_pkg::out_beat_t      o_sramrd
);
	int fail_cnt = 0;

	// source holds rdy and payload until ack
	assert property (@(posedge i_clk) disable iff (!i_rst)
		o_dramra_rdy && !i_dramra_ack |=> o_dramra_rdy && $stable(o_dramra))
	else begin
		fail_cnt++;
		$error("o_dramra changed or dropped before ack");
	end

	assert property (@(posedge i_clk) disable iff (!i_rst)
		o_sramrd_rdy && !i_sramrd_ack |=> o_sramrd_rdy && $stable(o_sramrd))
	else begin
		fail_cnt++;
		$error("o_sramrd changed or dropped before ack");
	end

	// no ack without rdy on any channel
	assert property (@(posedge i_clk) disable iff (!i_rst)
		(!o_req_ack || i_req_rdy) && (!i_dramra_ack || o_dramra_rdy)
		&& (!o_dramrd_ack || i_dramrd_rdy) && (!i_sramrd_ack || o_sramrd_rdy))
	else begin
		fail_cnt++;
		$error("ack seen without rdy");
	end

endmodule

bind read_pipeline tb_read_pipeline_assertions u_assert (.*);

//--- tb_read_pipeline.sv
`timescale 1ns/1ps

module tb_read_pipeline;
	import read_pipe_pkg::*;

	localparam int N_SLOTS = 4;
	localparam logic [31:0] SEED = 32'hbc59bda7;
	localparam logic [DBW-1:0] DATA_KEY = 16'h5a3c;
	localparam int N_DIRECT = 8;
	localparam int N_STALL = 8;
	localparam int N_RAND = 60;

	logic        i_clk;
	logic        i_rst;
	chunk_req_t  i_req;
	logic        i_req_rdy;
	logic        o_req_ack;
	cfg_t        cfg [N_CFG];
	logic        o_dramra_rdy;
	logic        i_dramra_ack;
	logic [GBW-1:0] o_dramra;
	logic        i_dramrd_rdy;
	logic        o_dramrd_ack;
	vec_t        i_dramrd;
	logic        o_sramrd_rdy;
	logic        i_sramrd_ack;
	out_beat_t   o_sramrd;

	// expected streams filled by the reference model at request ack
	logic [GBW-1:0] exp_addr [$];
	vec_t           exp_vec [$];
	logic           exp_last [$];
	logic [GBW-1:0] dram_q [$];
	chunk_req_t     req_q [$];
	chunk_req_t     all_reqs [$];

	chunk_req_t     gen_req;
	logic [GBW-1:0] exp_a;
	vec_t           exp_v;
	logic           exp_l;
	logic [31:0]    rng_gen;
	logic [31:0]    rng_dram;
	logic [31:0]    rng_out;
	int             dram_wait;
	int             err_cnt;
	int             vec_checked;
	int             vec_expected;
	int             req_acked;
	int             acked_base;
	int             total_beats;
	int             cycle_limit;
	int             cycles;
	logic           out_stall;
	logic           rand_mode;

	read_pipeline #(.N_SLOTS(N_SLOTS)) uut (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_req(i_req), .i_req_rdy(i_req_rdy), .o_req_ack(o_req_ack),
		.i_cfg(cfg),
		.o_dramra_rdy(o_dramra_rdy), .i_dramra_ack(i_dramra_ack), .o_dramra(o_dramra),
		.i_dramrd_rdy(i_dramrd_rdy), .o_dramrd_ack(o_dramrd_ack), .i_dramrd(i_dramrd),
		.o_sramrd_rdy(o_sramrd_rdy), .i_sramrd_ack(i_sramrd_ack), .o_sramrd(o_sramrd)
	);

	// ====================
	// helpers and reference
	// ====================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// word k of the beat at address a
	function automatic vec_t beat_data(input logic [GBW-1:0] a);
		vec_t v;
		for (int k = 0; k < VSIZE; k++) begin
			v[k] = DBW'(32'(a) * 4 + k) ^ DATA_KEY;
		end
		return v;
	endfunction

	function automatic void add_expected(input chunk_req_t r);
		cfg_t           c;
		logic [GBW-1:0] base;
		c = cfg[r.cfg_id];
		base = GBW'(int'(c.base) + int'(r.idx) * int'(c.stride));
		for (int b = 0; b < int'(c.beats); b++) begin
			exp_addr.push_back(base + GBW'(b));
			exp_vec.push_back(beat_data(base + GBW'(b)));
			exp_last.push_back(b == int'(c.beats) - 1);
		end
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		err_cnt++;
		$display("FAILED %s: expected %h, actual %h", name, exp, act);
	endtask

	task automatic flag_error(input string msg);
		err_cnt++;
		$display("ERROR: %s", msg);
	endtask

	task automatic check_idle();
		assert (!o_dramra_rdy && !o_sramrd_rdy && !o_req_ack && !o_dramrd_ack)
		else flag_error("a handshake output is active after reset before any request");
	endtask

	task automatic queue_requests(input int first, input int count);
		for (int i = first; i < first + count; i++) begin
			req_q.push_back(all_reqs[i]);
			vec_expected += int'(cfg[all_reqs[i].cfg_id].beats);
		end
	endtask

	task automatic wait_drained();
		while (vec_checked != vec_expected || req_q.size() != 0) begin
			@(posedge i_clk);
		end
		repeat (4) @(posedge i_clk);
		@(negedge i_clk);
	endtask

	task automatic print_summary();
		$display("tb_read_pipeline: %0d errors (%0d checks, %0d assertions), %0d vectors",
			err_cnt + uut.u_assert.fail_cnt, err_cnt, uut.u_assert.fail_cnt, vec_checked);
	endtask

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	// ====================
	// request driver
	// ====================

	always @(posedge i_clk) begin
		if (i_req_rdy && o_req_ack) begin
			add_expected(i_req);
			req_acked <= req_acked + 1;
			i_req_rdy <= 1'b0;
		end else if (!i_req_rdy && req_q.size() != 0) begin
			i_req <= req_q.pop_front();
			i_req_rdy <= 1'b1;
		end
	end

	// dram model with address and data channels in one process
	always @(posedge i_clk) begin
		rng_dram = xorshift(rng_dram);
		if (o_dramra_rdy && i_dramra_ack) begin
			if (exp_addr.size() == 0) begin
				flag_error("DRAM address issued with no request outstanding");
			end else begin
				exp_a = exp_addr.pop_front();
				assert (o_dramra == exp_a)
				else report_mismatch("dram address", 64'(exp_a), 64'(o_dramra));
			end
			dram_q.push_back(o_dramra);
			i_dramra_ack <= 1'b0;
		end else if (o_dramra_rdy && (!rand_mode || rng_dram[0])) begin
			i_dramra_ack <= 1'b1;
		end
		if (i_dramrd_rdy && o_dramrd_ack) begin
			i_dramrd_rdy <= 1'b0;
		end else if (!i_dramrd_rdy && dram_q.size() != 0) begin
			if (dram_wait != 0) begin
				dram_wait = dram_wait - 1;
			end else begin
				i_dramrd <= beat_data(dram_q.pop_front());
				i_dramrd_rdy <= 1'b1;
				dram_wait = rand_mode ? int'(rng_dram[10:8]) % 5 : 0;
			end
		end
	end

	// output sink and comparison
	always @(posedge i_clk) begin
		rng_out = xorshift(rng_out);
		if (o_sramrd_rdy && i_sramrd_ack) begin
			if (exp_vec.size() == 0) begin
				flag_error("output vector with no expected vector left");
			end else begin
				exp_v = exp_vec.pop_front();
				exp_l = exp_last.pop_front();
				assert (o_sramrd.data == exp_v)
				else report_mismatch("output vector", 64'(exp_v), 64'(o_sramrd.data));
				assert (o_sramrd.last == exp_l)
				else report_mismatch("last flag", 64'(exp_l), 64'(o_sramrd.last));
			end
			vec_checked++;
			i_sramrd_ack <= 1'b0;
		end else if (o_sramrd_rdy && !out_stall && (!rand_mode || rng_out[1:0] != 2'b00)) begin
			i_sramrd_ack <= 1'b1;
		end
	end

	always @(posedge i_clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			flag_error($sformatf("timeout after %0d cycles", cycles));
			print_summary();
			$display("=== FAIL ===");
			$finish;
		end
	end

	// ====================
	// main sequence
	// ====================

	initial begin
		i_rst = 1'b0;
		i_req = '0;
		i_req_rdy = 1'b0;
		i_dramra_ack = 1'b0;
		i_dramrd_rdy = 1'b0;
		i_dramrd = '0;
		i_sramrd_ack = 1'b0;
		out_stall = 1'b0;
		rand_mode = 1'b0;
		rng_gen = SEED;
		rng_dram = SEED ^ 32'h0000_ffff;
		rng_out = SEED ^ 32'hffff_0000;
		dram_wait = 0;
		err_cnt = 0;
		vec_checked = 0;
		vec_expected = 0;
		req_acked = 0;
		cycles = 0;
		total_beats = 0;
		// one length per entry from 1 to 4 beats
		cfg[0] = '{base: 24'h001000, stride: 24'd4, beats: BEAT_BW'(1)};
		cfg[1] = '{base: 24'h020000, stride: 24'd8, beats: BEAT_BW'(2)};
		cfg[2] = '{base: 24'h3ff000, stride: 24'd3, beats: BEAT_BW'(3)};
		cfg[3] = '{base: 24'h7ffe00, stride: 24'd5, beats: BEAT_BW'(4)};
		for (int i = 0; i < N_DIRECT + N_STALL + N_RAND; i++) begin
			rng_gen = xorshift(rng_gen);
			if (i < N_DIRECT + N_STALL) begin
				gen_req.cfg_id = CFG_BW'(i % N_CFG);
				gen_req.idx = IDX_BW'(i * 7 + 3);
			end else begin
				gen_req.cfg_id = rng_gen[CFG_BW-1:0];
				gen_req.idx = rng_gen[15:8];
			end
			all_reqs.push_back(gen_req);
			total_beats += int'(cfg[gen_req.cfg_id].beats);
		end
		cycle_limit = 40 * total_beats + 500;

		repeat (5) @(posedge i_clk);
		i_rst <= 1'b1;
		repeat (4) begin
			@(negedge i_clk);
			check_idle();
		end

		queue_requests(0, N_DIRECT);
		wait_drained();

		// output held off so head plus allocated slots bound the acks
		out_stall <= 1'b1;
		acked_base = req_acked;
		queue_requests(N_DIRECT, N_STALL);
		while (req_acked - acked_base < N_SLOTS + 1) begin
			@(posedge i_clk);
		end
		repeat (40) @(posedge i_clk);
		assert (req_acked - acked_base <= N_SLOTS + 1)
		else flag_error($sformatf("%0d requests acked while output was stalled",
			req_acked - acked_base));
		out_stall <= 1'b0;
		wait_drained();

		rand_mode <= 1'b1;
		queue_requests(N_DIRECT + N_STALL, N_RAND);
		wait_drained();

		print_summary();
		if (err_cnt + uut.u_assert.fail_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- src.f
read_pipe_pkg.sv
chunk_head.sv
chunk_allocator.sv
dram_addr_looper.sv
sram_write_collector.sv
local_buffer.sv
chunk_readout.sv
read_pipeline.sv
tb_read_pipeline_assertions.sv
tb_read_pipeline.sv

//--- Bender.yml
package:
  name: read_pipeline

sources:
  - read_pipe_pkg.sv
  - chunk_head.sv
  - chunk_allocator.sv
  - dram_addr_looper.sv
  - sram_write_collector.sv
  - local_buffer.sv
  - chunk_readout.sv
  - read_pipeline.sv
  - target: test
    files:
      - tb_read_pipeline_assertions.sv
      - tb_read_pipeline.sv
